//--- Bender.yml
package:
  name: im2col_param_unit

sources:
  - files:
      - source/im2col_pkg.sv
      - source/im2col_axil_regs.sv
      - source/im2col_param_fsm.sv
      - source/im2col_desc_fifo.sv
      - source/im2col_param_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_im2col_param_unit.sv

//--- sim.f
+incdir+include
source/im2col_pkg.sv
source/im2col_axil_regs.sv
source/im2col_param_fsm.sv
source/im2col_desc_fifo.sv
source/im2col_param_unit.sv
verification/tb_im2col_param_unit.sv

//--- source/im2col_axil_regs.sv
`timescale 1ns/1ns
`default_nettype none

module im2col_axil_regs (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                s_awvalid_i,
  input  wire im2col_pkg::addr_t   s_awaddr_i,
  input  wire logic                s_wvalid_i,
  input  wire logic [31:0]         s_wdata_i,
  input  wire logic                s_bready_i,
  input  wire logic                s_arvalid_i,
  input  wire im2col_pkg::addr_t   s_araddr_i,
  input  wire logic                s_rready_i,
  input  wire logic                busy_i,
  input  wire logic                done_i,
  output logic                     s_awready_o,
  output logic                     s_wready_o,
  output logic                     s_bvalid_o,
  output logic [1:0]               s_bresp_o,
  output logic                     s_arready_o,
  output logic                     s_rvalid_o,
  output logic [31:0]              s_rdata_o,
  output logic [1:0]               s_rresp_o,
  output im2col_pkg::addr_t        src_ptr_o,
  output im2col_pkg::addr_t        dst_ptr_o,
  output im2col_pkg::dim_t         ih_o,
  output im2col_pkg::dim_t         iw_o,
  output im2col_pkg::dim_t         n_patches_h_o,
  output im2col_pkg::dim_t         n_patches_w_o,
  output im2col_pkg::dim_t         ch_col_o,
  output im2col_pkg::small_t       fh_o,
  output im2col_pkg::small_t       fw_o,
  output im2col_pkg::small_t       num_ch_o,
  output im2col_pkg::small_t       batch_o,
  output logic [5:0]               pad_top_o,
  output logic [5:0]               pad_left_o,
  output logic [3:0]               log_s1_o,
  output logic [3:0]               log_s2_o,
  output logic [1:0]               data_type_o,
  output im2col_pkg::spad_t        last_patch_h_o,
  output im2col_pkg::spad_t        last_patch_w_o,
  output logic                     start_o
);

  logic        wr_en;
  logic        rd_en;
  logic        bvalid_q;
  logic        rvalid_q;
  logic        start_q;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic [31:0] src_q;
  logic [31:0] dst_q;
  logic [31:0] img_q;
  logic [31:0] kern_q;
  logic [31:0] pad_q;
  logic [31:0] patch_q;
  logic [15:0] last_q;
  logic [15:0] chcol_q;

  // Address and data must arrive together, one outstanding response.
  assign wr_en = s_awvalid_i && s_wvalid_i && !bvalid_q;
  assign rd_en = s_arvalid_i && !rvalid_q;

  assign s_awready_o = wr_en;
  assign s_wready_o  = wr_en;
  assign s_bvalid_o  = bvalid_q;
  assign s_bresp_o   = 2'b00;
  assign s_arready_o = rd_en;
  assign s_rvalid_o  = rvalid_q;
  assign s_rdata_o   = rdata_q;
  assign s_rresp_o   = 2'b00;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      start_q  <= 1'b0;
      src_q    <= '0;
      dst_q    <= '0;
      img_q    <= '0;
      kern_q   <= '0;
      pad_q    <= '0;
      patch_q  <= '0;
      last_q   <= '0;
      chcol_q  <= '0;
    end else begin
      // Start only from idle.
      start_q <= wr_en && (s_awaddr_i == im2col_pkg::REG_CTRL) && s_wdata_i[0] && !busy_i;
      if (wr_en) begin
        bvalid_q <= 1'b1;
      end else if (s_bready_i) begin
        bvalid_q <= 1'b0;
      end
      // Configuration is frozen during a run.
      if (wr_en && !busy_i) begin
        case (s_awaddr_i)
          im2col_pkg::REG_SRC:   src_q   <= s_wdata_i;
          im2col_pkg::REG_DST:   dst_q   <= s_wdata_i;
          im2col_pkg::REG_IMG:   img_q   <= s_wdata_i;
          im2col_pkg::REG_KERN:  kern_q  <= s_wdata_i;
          im2col_pkg::REG_PAD:   pad_q   <= s_wdata_i & 32'h03FF_3F3F;
          im2col_pkg::REG_PATCH: patch_q <= s_wdata_i;
          im2col_pkg::REG_LAST:  last_q  <= s_wdata_i[15:0];
          im2col_pkg::REG_CHCOL: chcol_q <= s_wdata_i[15:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (s_araddr_i)
      im2col_pkg::REG_STATUS: rdata_d = {30'b0, done_i, busy_i};
      im2col_pkg::REG_SRC:    rdata_d = src_q;
      im2col_pkg::REG_DST:    rdata_d = dst_q;
      im2col_pkg::REG_IMG:    rdata_d = img_q;
      im2col_pkg::REG_KERN:   rdata_d = kern_q;
      im2col_pkg::REG_PAD:    rdata_d = pad_q;
      im2col_pkg::REG_PATCH:  rdata_d = patch_q;
      im2col_pkg::REG_LAST:   rdata_d = {16'b0, last_q};
      im2col_pkg::REG_CHCOL:  rdata_d = {16'b0, chcol_q};
      default:                rdata_d = 32'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (rd_en) begin
      rvalid_q <= 1'b1;
    end else if (s_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign start_o        = start_q;
  assign src_ptr_o      = src_q;
  assign dst_ptr_o      = dst_q;
  assign iw_o           = img_q[15:0];
  assign ih_o           = img_q[31:16];
  assign fw_o           = kern_q[7:0];
  assign fh_o           = kern_q[15:8];
  assign num_ch_o       = kern_q[23:16];
  assign batch_o        = kern_q[31:24];
  assign pad_top_o      = pad_q[5:0];
  assign pad_left_o     = pad_q[13:8];
  assign log_s1_o       = pad_q[19:16];
  assign log_s2_o       = pad_q[23:20];
  assign data_type_o    = pad_q[25:24];
  assign n_patches_w_o  = patch_q[15:0];
  assign n_patches_h_o  = patch_q[31:16];
  assign last_patch_w_o = last_q[7:0];
  assign last_patch_h_o = last_q[15:8];
  assign ch_col_o       = chcol_q;

endmodule

`default_nettype wire

//--- source/im2col_desc_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module im2col_desc_fifo #(
  parameter int unsigned DEPTH = im2col_pkg::DESC_FIFO_DEPTH_DEFAULT,
  parameter int unsigned WIDTH = im2col_pkg::DESC_W
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             push_i,
  input  wire logic [WIDTH-1:0] data_i,
  input  wire logic             ready_i,
  output logic                  full_o,
  output logic                  valid_o,
  output logic [WIDTH-1:0]      data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wptr_q, rptr_q;
  logic [PTR_W:0]   count_q;
  logic             pop;

  // Head entry is presented directly.
  assign valid_o = count_q != '0;
  assign full_o  = count_q == (PTR_W + 1)'(DEPTH);
  assign data_o  = mem_q[rptr_q];
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_i) begin
        wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- source/im2col_param_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module im2col_param_fsm (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire im2col_pkg::addr_t  src_ptr_i,
  input  wire im2col_pkg::addr_t  dst_ptr_i,
  input  wire im2col_pkg::dim_t   ih_i,
  input  wire im2col_pkg::dim_t   iw_i,
  input  wire im2col_pkg::dim_t   n_patches_h_i,
  input  wire im2col_pkg::dim_t   n_patches_w_i,
  input  wire im2col_pkg::dim_t   ch_col_i,
  input  wire im2col_pkg::small_t fh_i,
  input  wire im2col_pkg::small_t fw_i,
  input  wire im2col_pkg::small_t num_ch_i,
  input  wire im2col_pkg::small_t batch_i,
  input  wire logic [5:0]         pad_top_i,
  input  wire logic [5:0]         pad_left_i,
  input  wire logic [3:0]         log_s1_i,
  input  wire logic [3:0]         log_s2_i,
  input  wire logic [1:0]         data_type_i,
  input  wire im2col_pkg::spad_t  last_patch_h_i,
  input  wire im2col_pkg::spad_t  last_patch_w_i,
  input  wire logic               start_i,
  input  wire logic               fifo_full_i,
  output logic                    fifo_push_o,
  output im2col_pkg::desc_t       desc_o,
  output logic                    busy_o,
  output logic                    done_o
);

  typedef enum logic [3:0] {
    IDLE, PRECOMP, COND_EVAL, ZEROS_COMP, INDEX_1, INDEX_2, INDEX_3, PUSH,
    OUT_PTR_UPDATE, POS_UPDATE
  } param_state_e;

  param_state_e state_q, state_d;

  // Loop nest counters.
  im2col_pkg::small_t w_offset_q, h_offset_q, im_c_q, batch_count_q;
  im2col_pkg::dim_t   ch_col_count_q;
  logic               done_q;
  logic               batch_wrap, last_desc, w_wrap, h_wrap;

  // Padding pipeline.
  im2col_pkg::small_t left_div_q, right_div_q, top_div_q, bottom_div_q;
  im2col_pkg::spad_t  right_sum, bottom_sum;
  logic               left_cond_q, right_cond_q, top_cond_q, bottom_cond_q;
  im2col_pkg::small_t n_left_q, n_right_q, n_top_q, n_bottom_q;

  // Index pipeline and pointers.
  im2col_pkg::addr_t  idx1_q, idx2_q, idx3_q, idx4_q, index;
  im2col_pkg::addr_t  out_ptr_q, out_inc, inc_full;
  im2col_pkg::dim_t   size_d1, size_d2;
  logic [1:0]         shift;

  assign batch_wrap = batch_count_q == batch_i - 8'd1;
  assign last_desc  = batch_wrap && (ch_col_count_q == ch_col_i - 16'd1);
  assign w_wrap     = w_offset_q == fw_i - 8'd1;
  assign h_wrap     = h_offset_q == fh_i - 8'd1;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:           state_d = start_i ? PRECOMP : IDLE;
      PRECOMP:        state_d = COND_EVAL;
      COND_EVAL:      state_d = ZEROS_COMP;
      ZEROS_COMP:     state_d = INDEX_1;
      INDEX_1:        state_d = INDEX_2;
      INDEX_2:        state_d = INDEX_3;
      // Hold the finished descriptor until there is room.
      INDEX_3:        state_d = fifo_full_i ? INDEX_3 : PUSH;
      PUSH:           state_d = last_desc ? IDLE : OUT_PTR_UPDATE;
      OUT_PTR_UPDATE: state_d = batch_wrap ? POS_UPDATE : COND_EVAL;
      POS_UPDATE:     state_d = COND_EVAL;
      default:        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      done_q         <= 1'b0;
      w_offset_q     <= '0;
      h_offset_q     <= '0;
      im_c_q         <= '0;
      batch_count_q  <= '0;
      ch_col_count_q <= '0;
    end else begin
      state_q <= state_d;
      unique case (state_q)
        IDLE: begin
          if (start_i) begin
            done_q         <= 1'b0;
            w_offset_q     <= '0;
            h_offset_q     <= '0;
            im_c_q         <= '0;
            batch_count_q  <= '0;
            ch_col_count_q <= '0;
          end
        end
        PUSH: begin
          if (last_desc) begin
            done_q <= 1'b1;
          end
        end
        OUT_PTR_UPDATE: begin
          batch_count_q <= batch_wrap ? 8'd0 : batch_count_q + 8'd1;
        end
        POS_UPDATE: begin
          ch_col_count_q <= ch_col_count_q + 16'd1;
          // Column, then row, then channel.
          if (!w_wrap) begin
            w_offset_q <= w_offset_q + 8'd1;
          end else begin
            w_offset_q <= '0;
            if (h_wrap) begin
              h_offset_q <= '0;
              im_c_q     <= im_c_q + 8'd1;
            end else begin
              h_offset_q <= h_offset_q + 8'd1;
            end
          end
        end
        default: ;
      endcase
    end
  end

  assign right_sum  = last_patch_w_i + w_offset_q + 8'd1;
  assign bottom_sum = last_patch_h_i + h_offset_q + 8'd1;

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE) begin
      out_ptr_q <= dst_ptr_i;
    end else if (state_q == OUT_PTR_UPDATE) begin
      out_ptr_q <= out_ptr_q + out_inc;
    end
    // Dividends follow the offsets of the current position.
    if (state_q == PRECOMP || state_q == COND_EVAL) begin
      left_div_q   <= {2'b0, pad_left_i} - w_offset_q - 8'd1;
      top_div_q    <= {2'b0, pad_top_i} - h_offset_q - 8'd1;
      right_div_q  <= last_patch_w_i + w_offset_q;
      bottom_div_q <= last_patch_h_i + h_offset_q;
    end
    if (state_q == COND_EVAL) begin
      left_cond_q   <= w_offset_q < {2'b0, pad_left_i};
      top_cond_q    <= h_offset_q < {2'b0, pad_top_i};
      right_cond_q  <= right_sum > 0;
      bottom_cond_q <= bottom_sum > 0;
    end
    if (state_q == ZEROS_COMP) begin
      n_left_q   <= left_cond_q ? 8'd1 + (left_div_q >> log_s1_i) : 8'd0;
      n_right_q  <= right_cond_q ? 8'd1 + (right_div_q >> log_s1_i) : 8'd0;
      n_top_q    <= top_cond_q ? 8'd1 + (top_div_q >> log_s2_i) : 8'd0;
      n_bottom_q <= bottom_cond_q ? 8'd1 + (bottom_div_q >> log_s2_i) : 8'd0;
    end
    // Four product stages, from ZEROS_COMP through INDEX_3.
    idx1_q <= 32'(batch_count_q) * 32'(num_ch_i) + 32'(im_c_q);
    idx2_q <= idx1_q * 32'(ih_i);
    idx3_q <= idx2_q + 32'(h_offset_q) - 32'(pad_top_i) + (32'(n_top_q) << log_s2_i);
    idx4_q <= idx3_q * 32'(iw_i) + 32'(w_offset_q) - 32'(pad_left_i);
  end

  assign shift    = 2'd2 - data_type_i;
  assign index    = idx4_q + (32'(n_left_q) << log_s1_i);
  assign out_inc  = (32'(n_patches_h_i) * 32'(n_patches_w_i)) << shift;
  assign size_d1  = n_patches_w_i - 16'(n_left_q) - 16'(n_right_q);
  assign size_d2  = n_patches_h_i - 16'(n_top_q) - 16'(n_bottom_q);
  assign inc_full = (32'(iw_i) << log_s2_i) - ((32'(size_d1) - 32'd1) << log_s1_i);

  assign desc_o.input_ptr      = src_ptr_i + (index << shift);
  assign desc_o.output_ptr     = out_ptr_q;
  assign desc_o.in_inc_d2      = inc_full[22:0];
  assign desc_o.n_zeros_top    = n_top_q;
  assign desc_o.n_zeros_bottom = n_bottom_q;
  assign desc_o.n_zeros_left   = n_left_q;
  assign desc_o.n_zeros_right  = n_right_q;
  assign desc_o.size_d1        = size_d1;
  assign desc_o.size_d2        = size_d2;

  assign fifo_push_o = state_q == PUSH;
  assign busy_o      = start_i || (state_q != IDLE);
  assign done_o      = done_q;

endmodule

`default_nettype wire

//--- source/im2col_param_unit.sv
`timescale 1ns/1ns
`default_nettype none

module im2col_param_unit #(
  parameter int unsigned DESC_FIFO_DEPTH = im2col_pkg::DESC_FIFO_DEPTH_DEFAULT
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                s_awvalid_i,
  input  wire im2col_pkg::addr_t   s_awaddr_i,
  input  wire logic                s_wvalid_i,
  input  wire logic [31:0]         s_wdata_i,
  input  wire logic                s_bready_i,
  input  wire logic                s_arvalid_i,
  input  wire im2col_pkg::addr_t   s_araddr_i,
  input  wire logic                s_rready_i,
  output logic                     s_awready_o,
  output logic                     s_wready_o,
  output logic                     s_bvalid_o,
  output logic [1:0]               s_bresp_o,
  output logic                     s_arready_o,
  output logic                     s_rvalid_o,
  output logic [31:0]              s_rdata_o,
  output logic [1:0]               s_rresp_o,
  input  wire logic                dma_desc_ready_i,
  output logic                     dma_desc_valid_o,
  output im2col_pkg::addr_t        dma_input_ptr_o,
  output im2col_pkg::addr_t        dma_output_ptr_o,
  output im2col_pkg::inc_t         dma_in_inc_d2_o,
  output im2col_pkg::small_t       dma_n_zeros_top_o,
  output im2col_pkg::small_t       dma_n_zeros_bottom_o,
  output im2col_pkg::small_t       dma_n_zeros_left_o,
  output im2col_pkg::small_t       dma_n_zeros_right_o,
  output im2col_pkg::dim_t         dma_size_d1_o,
  output im2col_pkg::dim_t         dma_size_d2_o
);

  im2col_pkg::addr_t  src_ptr, dst_ptr;
  im2col_pkg::dim_t   ih, iw, n_patches_h, n_patches_w, ch_col;
  im2col_pkg::small_t fh, fw, num_ch, batch;
  logic [5:0]         pad_top, pad_left;
  logic [3:0]         log_s1, log_s2;
  logic [1:0]         data_type;
  im2col_pkg::spad_t  last_patch_h, last_patch_w;
  logic               start, busy, done, push, full;
  im2col_pkg::desc_t  desc, head;

  im2col_axil_regs im2col_axil_regs_inst (
    .clk_i, .rst_ni,
    .s_awvalid_i, .s_awaddr_i, .s_wvalid_i, .s_wdata_i, .s_bready_i,
    .s_arvalid_i, .s_araddr_i, .s_rready_i,
    .busy_i(busy), .done_i(done),
    .s_awready_o, .s_wready_o, .s_bvalid_o, .s_bresp_o,
    .s_arready_o, .s_rvalid_o, .s_rdata_o, .s_rresp_o,
    .src_ptr_o(src_ptr), .dst_ptr_o(dst_ptr), .ih_o(ih), .iw_o(iw),
    .n_patches_h_o(n_patches_h), .n_patches_w_o(n_patches_w), .ch_col_o(ch_col),
    .fh_o(fh), .fw_o(fw), .num_ch_o(num_ch), .batch_o(batch),
    .pad_top_o(pad_top), .pad_left_o(pad_left), .log_s1_o(log_s1), .log_s2_o(log_s2),
    .data_type_o(data_type), .last_patch_h_o(last_patch_h), .last_patch_w_o(last_patch_w),
    .start_o(start)
  );

  im2col_param_fsm im2col_param_fsm_inst (
    .clk_i, .rst_ni,
    .src_ptr_i(src_ptr), .dst_ptr_i(dst_ptr), .ih_i(ih), .iw_i(iw),
    .n_patches_h_i(n_patches_h), .n_patches_w_i(n_patches_w), .ch_col_i(ch_col),
    .fh_i(fh), .fw_i(fw), .num_ch_i(num_ch), .batch_i(batch),
    .pad_top_i(pad_top), .pad_left_i(pad_left), .log_s1_i(log_s1), .log_s2_i(log_s2),
    .data_type_i(data_type), .last_patch_h_i(last_patch_h), .last_patch_w_i(last_patch_w),
    .start_i(start), .fifo_full_i(full),
    .fifo_push_o(push), .desc_o(desc), .busy_o(busy), .done_o(done)
  );

  im2col_desc_fifo #(
    .DEPTH(DESC_FIFO_DEPTH),
    .WIDTH(im2col_pkg::DESC_W)
  ) im2col_desc_fifo_inst (
    .clk_i, .rst_ni,
    .push_i(push), .data_i(desc), .ready_i(dma_desc_ready_i),
    .full_o(full), .valid_o(dma_desc_valid_o), .data_o(head)
  );

  // Head entry split into the DMA fields.
  assign dma_input_ptr_o      = head.input_ptr;
  assign dma_output_ptr_o     = head.output_ptr;
  assign dma_in_inc_d2_o      = head.in_inc_d2;
  assign dma_n_zeros_top_o    = head.n_zeros_top;
  assign dma_n_zeros_bottom_o = head.n_zeros_bottom;
  assign dma_n_zeros_left_o   = head.n_zeros_left;
  assign dma_n_zeros_right_o  = head.n_zeros_right;
  assign dma_size_d1_o        = head.size_d1;
  assign dma_size_d2_o        = head.size_d2;

endmodule

`default_nettype wire

//--- source/im2col_pkg.sv
`default_nettype none

package im2col_pkg;

  // Widths that carry a meaning.
  typedef logic [31:0]        addr_t;
  typedef logic [15:0]        dim_t;
  typedef logic [7:0]         small_t;
  typedef logic signed [7:0]  spad_t;
  typedef logic [22:0]        inc_t;

  // One 2D DMA descriptor, first field in the top bits.
  typedef struct packed {
    addr_t  input_ptr;
    addr_t  output_ptr;
    inc_t   in_inc_d2;
    small_t n_zeros_top;
    small_t n_zeros_bottom;
    small_t n_zeros_left;
    small_t n_zeros_right;
    dim_t   size_d1;
    dim_t   size_d2;
  } desc_t;

  // 151 bits.
  localparam int unsigned DESC_W = $bits(desc_t);

  // AXI4-Lite register byte offsets.
  localparam addr_t REG_CTRL   = 32'h00;
  localparam addr_t REG_STATUS = 32'h04;
  localparam addr_t REG_SRC    = 32'h08;
  localparam addr_t REG_DST    = 32'h0C;
  localparam addr_t REG_IMG    = 32'h10;
  localparam addr_t REG_KERN   = 32'h14;
  localparam addr_t REG_PAD    = 32'h18;
  localparam addr_t REG_PATCH  = 32'h1C;
  localparam addr_t REG_LAST   = 32'h20;
  localparam addr_t REG_CHCOL  = 32'h24;

  localparam int unsigned DESC_FIFO_DEPTH_DEFAULT = 4;

endpackage

`default_nettype wire

//--- include/im2col_ref_model.svh
`ifndef IM2COL_REF_MODEL_SVH
`define IM2COL_REF_MODEL_SVH

// Expected descriptors in issue order, position outer and batch inner.
function automatic void im2col_ref_model(
  input  im2col_pkg::addr_t  src_ptr,
  input  im2col_pkg::addr_t  dst_ptr,
  input  im2col_pkg::dim_t   ih,
  input  im2col_pkg::dim_t   iw,
  input  im2col_pkg::dim_t   n_patches_h,
  input  im2col_pkg::dim_t   n_patches_w,
  input  im2col_pkg::dim_t   ch_col,
  input  im2col_pkg::small_t fh,
  input  im2col_pkg::small_t fw,
  input  im2col_pkg::small_t num_ch,
  input  im2col_pkg::small_t batch,
  input  logic [5:0]         pad_top,
  input  logic [5:0]         pad_left,
  input  logic [3:0]         log_s1,
  input  logic [3:0]         log_s2,
  input  logic [1:0]         data_type,
  input  im2col_pkg::spad_t  last_patch_h,
  input  im2col_pkg::spad_t  last_patch_w,
  output im2col_pkg::desc_t  exp_q[$]
);
  im2col_pkg::small_t w, h, c, left, right, top, bottom;
  im2col_pkg::spad_t  right_sum, bottom_sum;
  im2col_pkg::addr_t  index, out_ptr, inc;
  logic [1:0]         shift;
  im2col_pkg::desc_t  d;
  exp_q.delete();
  w = '0;
  h = '0;
  c = '0;
  shift = 2'd2 - data_type;
  out_ptr = dst_ptr;
  for (int p = 0; p < int'(ch_col); p++) begin
    // Zero counts depend on the kernel position only.
    right_sum = last_patch_w + w + 8'd1;
    bottom_sum = last_patch_h + h + 8'd1;
    left = (w < {2'b0, pad_left}) ? 8'd1 + (({2'b0, pad_left} - w - 8'd1) >> log_s1) : 8'd0;
    top = (h < {2'b0, pad_top}) ? 8'd1 + (({2'b0, pad_top} - h - 8'd1) >> log_s2) : 8'd0;
    right = (right_sum > 0) ? 8'd1 + ((last_patch_w + w) >> log_s1) : 8'd0;
    bottom = (bottom_sum > 0) ? 8'd1 + ((last_patch_h + h) >> log_s2) : 8'd0;
    for (int b = 0; b < int'(batch); b++) begin
      index = (32'(b) * 32'(num_ch) + 32'(c)) * 32'(ih);
      index = index + 32'(h) - 32'(pad_top) + (32'(top) << log_s2);
      index = index * 32'(iw) + 32'(w) - 32'(pad_left) + (32'(left) << log_s1);
      d.input_ptr = src_ptr + (index << shift);
      d.output_ptr = out_ptr;
      d.n_zeros_top = top;
      d.n_zeros_bottom = bottom;
      d.n_zeros_left = left;
      d.n_zeros_right = right;
      d.size_d1 = n_patches_w - 16'(left) - 16'(right);
      d.size_d2 = n_patches_h - 16'(top) - 16'(bottom);
      inc = (32'(iw) << log_s2) - ((32'(d.size_d1) - 32'd1) << log_s1);
      d.in_inc_d2 = inc[22:0];
      exp_q.push_back(d);
      out_ptr = out_ptr + ((32'(n_patches_h) * 32'(n_patches_w)) << shift);
    end
    if (w != fw - 8'd1) begin
      w = w + 8'd1;
    end else begin
      w = '0;
      if (h != fh - 8'd1) begin
        h = h + 8'd1;
      end else begin
        h = '0;
        c = c + 8'd1;
      end
    end
  end
endfunction

`endif

//--- verification/tb_im2col_param_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_im2col_param_unit;

  logic        clk;
  logic        rst_n;
  logic        s_awvalid;
  logic [31:0] s_awaddr;
  logic        s_wvalid;
  logic [31:0] s_wdata;
  logic        s_bready;
  logic        s_arvalid;
  logic [31:0] s_araddr;
  logic        s_rready;
  logic        s_awready;
  logic        s_wready;
  logic        s_bvalid;
  logic [1:0]  s_bresp;
  logic        s_arready;
  logic        s_rvalid;
  logic [31:0] s_rdata;
  logic [1:0]  s_rresp;
  logic        dma_ready;
  logic        dma_valid;
  logic [31:0] dma_input_ptr;
  logic [31:0] dma_output_ptr;
  logic [22:0] dma_in_inc_d2;
  logic [7:0]  dma_n_zeros_top;
  logic [7:0]  dma_n_zeros_bottom;
  logic [7:0]  dma_n_zeros_left;
  logic [7:0]  dma_n_zeros_right;
  logic [15:0] dma_size_d1;
  logic [15:0] dma_size_d2;

  // Current convolution geometry.
  im2col_pkg::addr_t  cfg_src, cfg_dst;
  im2col_pkg::dim_t   cfg_ih, cfg_iw, cfg_nph, cfg_npw, cfg_ch_col;
  im2col_pkg::small_t cfg_fh, cfg_fw, cfg_num_ch, cfg_batch;
  logic [5:0]         cfg_pad_top, cfg_pad_left;
  logic [3:0]         cfg_log_s1, cfg_log_s2;
  logic [1:0]         cfg_data_type;
  im2col_pkg::spad_t  cfg_lph, cfg_lpw;

  im2col_pkg::desc_t  expected_q[$];
  im2col_pkg::desc_t  run_q[$];
  im2col_pkg::desc_t  exp_d;
  int                 expected_total;
  int                 rx_count;
  int                 cycles;
  integer             seed;
  integer             rnd;
  logic               random_ready;

  `include "im2col_ref_model.svh"

  im2col_param_unit #(
    .DESC_FIFO_DEPTH(im2col_pkg::DESC_FIFO_DEPTH_DEFAULT)
  ) im2col_param_unit_inst (
    .clk_i(clk), .rst_ni(rst_n),
    .s_awvalid_i(s_awvalid), .s_awaddr_i(s_awaddr), .s_wvalid_i(s_wvalid),
    .s_wdata_i(s_wdata), .s_bready_i(s_bready), .s_arvalid_i(s_arvalid),
    .s_araddr_i(s_araddr), .s_rready_i(s_rready),
    .s_awready_o(s_awready), .s_wready_o(s_wready), .s_bvalid_o(s_bvalid),
    .s_bresp_o(s_bresp), .s_arready_o(s_arready), .s_rvalid_o(s_rvalid),
    .s_rdata_o(s_rdata), .s_rresp_o(s_rresp),
    .dma_desc_ready_i(dma_ready), .dma_desc_valid_o(dma_valid),
    .dma_input_ptr_o(dma_input_ptr), .dma_output_ptr_o(dma_output_ptr),
    .dma_in_inc_d2_o(dma_in_inc_d2), .dma_n_zeros_top_o(dma_n_zeros_top),
    .dma_n_zeros_bottom_o(dma_n_zeros_bottom), .dma_n_zeros_left_o(dma_n_zeros_left),
    .dma_n_zeros_right_o(dma_n_zeros_right), .dma_size_d1_o(dma_size_d1),
    .dma_size_d2_o(dma_size_d2)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk);
    s_awvalid = 1'b1;
    s_awaddr  = addr;
    s_wvalid  = 1'b1;
    s_wdata   = data;
    #1;
    while (!s_awready) begin
      @(negedge clk);
      #1;
    end
    check_value("wready", 32'(s_wready), 32'd1);
    @(negedge clk);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    check_value("bvalid", 32'(s_bvalid), 32'd1);
    check_value("bresp", 32'(s_bresp), 32'd0);
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    @(negedge clk);
    s_arvalid = 1'b1;
    s_araddr  = addr;
    #1;
    while (!s_arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    s_arvalid = 1'b0;
    check_value("rvalid", 32'(s_rvalid), 32'd1);
    check_value("rresp", 32'(s_rresp), 32'd0);
    data = s_rdata;
  endtask

  // Bits that each register keeps.
  function automatic logic [31:0] reg_mask(input logic [31:0] addr);
    case (addr)
      im2col_pkg::REG_PAD:   return 32'h03FF_3F3F;
      im2col_pkg::REG_LAST:  return 32'h0000_FFFF;
      im2col_pkg::REG_CHCOL: return 32'h0000_FFFF;
      default:               return 32'hFFFF_FFFF;
    endcase
  endfunction

  task automatic check_registers();
    logic [31:0] addr;
    logic [31:0] value;
    logic [31:0] got;
    for (int i = 0; i < 8; i++) begin
      addr  = im2col_pkg::REG_SRC + 32'(4 * i);
      value = $random(seed);
      write_reg(addr, value);
      read_reg(addr, got);
      check_value("register readback", got, value & reg_mask(addr));
    end
    read_reg(32'h28, got);
    check_value("unknown offset 0x28", got, 32'h0);
    read_reg(32'h100, got);
    check_value("unknown offset 0x100", got, 32'h0);
  endtask

  task automatic program_config();
    write_reg(im2col_pkg::REG_SRC, cfg_src);
    write_reg(im2col_pkg::REG_DST, cfg_dst);
    write_reg(im2col_pkg::REG_IMG, {cfg_ih, cfg_iw});
    write_reg(im2col_pkg::REG_KERN, {cfg_batch, cfg_num_ch, cfg_fh, cfg_fw});
    write_reg(im2col_pkg::REG_PAD, {6'b0, cfg_data_type, cfg_log_s2, cfg_log_s1,
                                    2'b0, cfg_pad_left, 2'b0, cfg_pad_top});
    write_reg(im2col_pkg::REG_PATCH, {cfg_nph, cfg_npw});
    write_reg(im2col_pkg::REG_LAST, {16'b0, cfg_lph, cfg_lpw});
    write_reg(im2col_pkg::REG_CHCOL, {16'b0, cfg_ch_col});
  endtask

  // Appends the model's list for the current geometry.
  task automatic queue_expected();
    im2col_ref_model(cfg_src, cfg_dst, cfg_ih, cfg_iw, cfg_nph, cfg_npw, cfg_ch_col,
                     cfg_fh, cfg_fw, cfg_num_ch, cfg_batch, cfg_pad_top, cfg_pad_left,
                     cfg_log_s1, cfg_log_s2, cfg_data_type, cfg_lph, cfg_lpw, run_q);
    foreach (run_q[i]) begin
      expected_q.push_back(run_q[i]);
    end
    expected_total = expected_total + run_q.size();
  endtask

  task automatic start_run();
    logic [31:0] status;
    rx_count = 0;
    write_reg(im2col_pkg::REG_CTRL, 32'h1);
    read_reg(im2col_pkg::REG_STATUS, status);
    check_value("STATUS after start", status, 32'h1);
  endtask

  task automatic finish_run();
    logic [31:0] status;
    status = '0;
    while (!status[1]) begin
      repeat (4) @(negedge clk);
      read_reg(im2col_pkg::REG_STATUS, status);
    end
    // Let the FIFO drain to the DMA.
    while (dma_valid) begin
      @(negedge clk);
    end
    // Quiet period catches any extra descriptor.
    repeat (40) @(negedge clk);
    read_reg(im2col_pkg::REG_STATUS, status);
    check_value("STATUS after run", status, 32'h2);
    check_value("descriptor count", rx_count, 32'(cfg_ch_col) * 32'(cfg_batch));
  endtask

  always @(negedge clk) begin
    if (random_ready) begin
      rnd = $random(seed);
      dma_ready = (rnd[3:0] == 4'd0);
    end else begin
      dma_ready = 1'b1;
    end
  end

  // Compare each accepted descriptor with the next expected one.
  always @(posedge clk) begin
    if (rst_n && dma_valid && dma_ready) begin
      if (expected_q.size() == 0) begin
        $display("Descriptor arrived at %0t ns while none was expected", $time);
        $display("Simulation failed");
        $fatal(1);
      end else begin
        exp_d = expected_q.pop_front();
        check_value("input_ptr", dma_input_ptr, exp_d.input_ptr);
        check_value("output_ptr", dma_output_ptr, exp_d.output_ptr);
        check_value("in_inc_d2", 32'(dma_in_inc_d2), 32'(exp_d.in_inc_d2));
        check_value("n_zeros_top", 32'(dma_n_zeros_top), 32'(exp_d.n_zeros_top));
        check_value("n_zeros_bottom", 32'(dma_n_zeros_bottom), 32'(exp_d.n_zeros_bottom));
        check_value("n_zeros_left", 32'(dma_n_zeros_left), 32'(exp_d.n_zeros_left));
        check_value("n_zeros_right", 32'(dma_n_zeros_right), 32'(exp_d.n_zeros_right));
        check_value("size_d1", 32'(dma_size_d1), 32'(exp_d.size_d1));
        check_value("size_d2", 32'(dma_size_d2), 32'(exp_d.size_d2));
        rx_count = rx_count + 1;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles <= 20 * expected_total + 2000) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("Timeout: descriptors stopped arriving after %0d cycles", cycles);
    $display("Simulation failed");
    $fatal(1);
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    s_awvalid = 1'b0;
    s_awaddr = '0;
    s_wvalid = 1'b0;
    s_wdata = '0;
    s_bready = 1'b1;
    s_arvalid = 1'b0;
    s_araddr = '0;
    s_rready = 1'b1;
    dma_ready = 1'b1;
    random_ready = 1'b0;
    seed = 35;
    expected_total = 0;
    rx_count = 0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    check_registers();

    // 3x3 kernel, two channels, no padding, 32-bit data.
    cfg_src = 32'h1000_0000;
    cfg_dst = 32'h2000_0000;
    cfg_ih = 16'd8;
    cfg_iw = 16'd8;
    cfg_fh = 8'd3;
    cfg_fw = 8'd3;
    cfg_num_ch = 8'd2;
    cfg_batch = 8'd2;
    cfg_pad_top = 6'd0;
    cfg_pad_left = 6'd0;
    cfg_log_s1 = 4'd0;
    cfg_log_s2 = 4'd0;
    cfg_data_type = 2'd0;
    cfg_nph = 16'd6;
    cfg_npw = 16'd6;
    cfg_lph = -8'sd3;
    cfg_lpw = -8'sd3;
    cfg_ch_col = 16'd18;
    program_config();
    queue_expected();
    start_run();
    finish_run();

    // Pad 1, stride 2, 8-bit data.
    cfg_src = 32'h3000_0101;
    cfg_dst = 32'h4000_0200;
    cfg_ih = 16'd9;
    cfg_iw = 16'd9;
    cfg_num_ch = 8'd1;
    cfg_pad_top = 6'd1;
    cfg_pad_left = 6'd1;
    cfg_log_s1 = 4'd1;
    cfg_log_s2 = 4'd1;
    cfg_data_type = 2'd2;
    cfg_nph = 16'd5;
    cfg_npw = 16'd5;
    cfg_lph = -8'sd2;
    cfg_lpw = -8'sd2;
    cfg_ch_col = 16'd9;
    program_config();
    queue_expected();
    start_run();
    finish_run();

    // Same geometry with the DMA stalling most cycles.
    cfg_dst = 32'h4800_0000;
    program_config();
    queue_expected();
    random_ready = 1'b1;
    start_run();
    finish_run();
    random_ready = 1'b0;

    // A start while busy is ignored and a second start restarts.
    cfg_dst = 32'h5000_0000;
    program_config();
    queue_expected();
    start_run();
    write_reg(im2col_pkg::REG_CTRL, 32'h1);
    finish_run();
    cfg_dst = 32'h5800_0040;
    write_reg(im2col_pkg::REG_DST, cfg_dst);
    queue_expected();
    start_run();
    finish_run();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
